/* common/oflow_pkg.sv */
// data-path constants for the optical-flow frame controller
// imported by every RTL block of the tracker

package oflow_pkg;

	// ------------------------------------------------------------------------
	// box and set geometry
	// ------------------------------------------------------------------------
	localparam int PE_NUM      = 4;   // boxes per set, one per lane
	localparam int MAX_BBOX    = 16;  // boxes per frame
	localparam int BBOX_W      = 16;  // x in [15:8], y in [7:0]
	localparam int SET_W       = 2;   // set index, MAX_BBOX / PE_NUM sets
	localparam int BBOX_CNT_W  = 5;   // box count 0..16

	// ------------------------------------------------------------------------
	// scoring and frame bookkeeping
	// ------------------------------------------------------------------------
	localparam int SCORE_W     = 9;   // |dx| + |dy|, two 8-bit terms
	localparam int FRAME_NUM_W = 8;   // committed frame counter

	// lane counts as a conflict once its score is above this
	localparam int SCORE_TH    = 40;

	// more conflicts than this in one frame and the frame is dropped
	localparam int CONFLICT_TH = 3;
	localparam int CONFLICT_W  = 5;   // saturating conflict count

endpackage

/* common/oflow_ctrl_pkg.sv */
// controller state and buffer command encodings
// used by the core FSM and the history buffer only

package oflow_ctrl_pkg;

	// frame sequencing states
	typedef enum logic [2:0] {
		IDLE_ST,       // waiting for frame_start
		SET_VARS_ST,   // set count and box counter loaded
		PE_ST,         // set handshake and scoring
		CONFLICT_ST,   // resolver run, frames after the first
		WRITE_ST       // bank commit
	} core_state_t;

	// history buffer command, one per cycle
	typedef enum logic [1:0] {
		BUF_NOP,
		BUF_STAGE,     // write captured set into staging bank
		BUF_COMMIT     // staging bank becomes history
	} buf_cmd_t;

endpackage

/* oflow_core/oflow_core_fsm_top.sv */
// frame sequencing FSM of the tracker core
// runs the ack side of the DMA set handshake, drives PE capture, resolver
// and buffer commands, and counts committed frames

`timescale 1ns/100ps

module oflow_core_fsm_top (
	input  logic                               clk,
	input  logic                               reset_N,
	input  logic                               frame_start,
	input  logic [oflow_pkg::BBOX_CNT_W-1:0]   num_bbox,
	input  logic                               set_req,
	input  logic                               done_write,
	input  logic                               done_cr,
	input  logic                               drop,
	output logic                               set_ack,
	output logic                               ready_new_frame,
	output logic                               capture,
	output logic [oflow_pkg::PE_NUM-1:0]       lane_en,
	output logic [oflow_pkg::SET_W-1:0]        set_idx,
	output oflow_ctrl_pkg::buf_cmd_t           buf_cmd,
	output logic                               start_cr,
	output logic                               clear_cr,
	output logic                               frame_done,
	output logic                               valid_id,
	output logic                               frame_dropped,
	output logic [oflow_pkg::FRAME_NUM_W-1:0]  frame_num
);

	import oflow_pkg::*;
	import oflow_ctrl_pkg::*;

	core_state_t state, next_state;

	logic [BBOX_CNT_W-1:0] nb_q;       // box count of the current frame
	logic [BBOX_CNT_W-1:0] nb_round;   // count rounded up to a whole set
	logic [BBOX_CNT_W-1:0] remain;     // boxes not yet captured
	logic [SET_W:0]        sets_left;  // one bit wider, holds 4
	logic                  step;       // second cycle of CONFLICT/WRITE

	assign nb_round = nb_q + BBOX_CNT_W'(PE_NUM - 1);

	// ------------------------------------------------------------------------
	// next state and per-cycle strobes
	// ------------------------------------------------------------------------
	always_comb begin
		next_state      = state;
		ready_new_frame = 1'b0;
		capture         = 1'b0;
		buf_cmd         = BUF_NOP;
		start_cr        = 1'b0;
		clear_cr        = 1'b0;
		case (state)
			IDLE_ST: begin
				ready_new_frame = 1'b1;
				if (frame_start)
					next_state = SET_VARS_ST;
			end
			SET_VARS_ST: begin
				clear_cr   = 1'b1;   // fresh conflict count per frame
				next_state = PE_ST;
			end
			PE_ST: begin
				if (set_req && !set_ack && sets_left != '0) begin
					capture = 1'b1;  // set_data stable while req high
					buf_cmd = BUF_STAGE;
				end
				// last set acked and its req released
				if (sets_left == '0 && !set_ack)
					next_state = (frame_num == '0) ? WRITE_ST : CONFLICT_ST;
			end
			CONFLICT_ST: begin
				start_cr = !step;
				if (done_cr)
					next_state = drop ? IDLE_ST : WRITE_ST;
			end
			WRITE_ST: begin
				if (!step)
					buf_cmd = BUF_COMMIT;
				if (done_write)
					next_state = IDLE_ST;
			end
			default: next_state = IDLE_ST;
		endcase
	end

	// lanes below the remaining box count
	always_comb begin
		for (int i = 0; i < PE_NUM; i++)
			lane_en[i] = (remain > BBOX_CNT_W'(i));
	end

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			state <= IDLE_ST;
			step  <= 1'b0;
		end else begin
			state <= next_state;
			step  <= (next_state == state);   // cleared on every state change
		end
	end

	// frame count latched with the start pulse
	always_ff @(posedge clk) begin
		if (state == IDLE_ST && frame_start)
			nb_q <= num_bbox;
	end

	// ------------------------------------------------------------------------
	// set counters and ack
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			remain    <= '0;
			sets_left <= '0;
			set_idx   <= '0;
			set_ack   <= 1'b0;
		end else if (state == SET_VARS_ST) begin
			remain    <= nb_q;
			sets_left <= (SET_W + 1)'(nb_round / PE_NUM);   // ceil(nb / PE_NUM)
			set_idx   <= '0;
		end else if (capture) begin
			remain    <= (remain > BBOX_CNT_W'(PE_NUM)) ? remain - BBOX_CNT_W'(PE_NUM) : '0;
			sets_left <= sets_left - 1'b1;
			set_idx   <= set_idx + 1'b1;
			set_ack   <= 1'b1;
		end else if (set_ack && !set_req) begin
			set_ack   <= 1'b0;   // phase 4, DMA released req
		end
	end

	// ------------------------------------------------------------------------
	// frame counter and end-of-frame report
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			frame_num     <= '0;
			frame_done    <= 1'b0;
			valid_id      <= 1'b0;
			frame_dropped <= 1'b0;
		end else begin
			frame_done    <= 1'b0;
			valid_id      <= 1'b0;
			frame_dropped <= 1'b0;
			if (state == CONFLICT_ST && done_cr && drop) begin
				frame_done    <= 1'b1;
				frame_dropped <= 1'b1;   // history and counter untouched
			end
			if (state == WRITE_ST && done_write) begin
				frame_done <= 1'b1;
				valid_id   <= (frame_num != '0);   // only after a resolver pass
				frame_num  <= frame_num + 1'b1;
			end
		end
	end

	// ack may only rise on a live request
	a_ack_on_req: assert property (@(posedge clk) disable iff (!reset_N)
		$rose(set_ack) |-> $past(set_req));

	// a captured set always carries at least one box
	a_capture_lanes: assert property (@(posedge clk) disable iff (!reset_N)
		capture |-> lane_en != '0);

endmodule

/* oflow_core/oflow_pe_array.sv */
// four-lane PE array, scores a captured set against history
// score per lane is |dx| + |dy|, registered one cycle after capture

`timescale 1ns/100ps

module oflow_pe_array (
	input  logic                                        clk,
	input  logic                                        reset_N,
	input  logic                                        capture,
	input  logic [oflow_pkg::PE_NUM-1:0]                lane_en,
	input  logic [oflow_pkg::SET_W-1:0]                 set_idx,
	input  logic [oflow_pkg::PE_NUM*oflow_pkg::BBOX_W-1:0]  set_data,
	input  logic [oflow_pkg::PE_NUM*oflow_pkg::BBOX_W-1:0]  hist_data,
	output logic [oflow_pkg::PE_NUM-1:0]                score_valid,
	output logic [oflow_pkg::PE_NUM*oflow_pkg::SCORE_W-1:0] score,
	output logic [oflow_pkg::SET_W-1:0]                 score_set
);

	import oflow_pkg::*;

	// manhattan distance between two packed boxes
	function automatic logic [SCORE_W-1:0] box_dist(input logic [BBOX_W-1:0] a,
	                                                input logic [BBOX_W-1:0] b);
		logic [BBOX_W/2-1:0] dx;
		logic [BBOX_W/2-1:0] dy;
		dx = (a[BBOX_W-1 -: BBOX_W/2] > b[BBOX_W-1 -: BBOX_W/2]) ?
		     a[BBOX_W-1 -: BBOX_W/2] - b[BBOX_W-1 -: BBOX_W/2] :
		     b[BBOX_W-1 -: BBOX_W/2] - a[BBOX_W-1 -: BBOX_W/2];
		dy = (a[BBOX_W/2-1:0] > b[BBOX_W/2-1:0]) ?
		     a[BBOX_W/2-1:0] - b[BBOX_W/2-1:0] :
		     b[BBOX_W/2-1:0] - a[BBOX_W/2-1:0];
		return SCORE_W'(dx) + SCORE_W'(dy);   // 9 bits, no overflow
	endfunction

	// valid mask, live for exactly one cycle per capture
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N)
			score_valid <= '0;
		else
			score_valid <= capture ? lane_en : '0;
	end

	// lane results, back-to-back captures allowed
	always_ff @(posedge clk) begin
		if (capture) begin
			score_set <= set_idx;
			for (int i = 0; i < PE_NUM; i++)
				if (lane_en[i])   // idle lanes keep old value
					score[i*SCORE_W +: SCORE_W] <=
						box_dist(set_data[i*BBOX_W +: BBOX_W], hist_data[i*BBOX_W +: BBOX_W]);
		end
	end

	// results only follow a capture
	a_valid_after_capture: assert property (@(posedge clk) disable iff (!reset_N)
		(score_valid != '0) |-> $past(capture));

endmodule

/* oflow_core/oflow_conflict_resolve.sv */
// per-frame conflict counter and keep/drop decision
// counts valid lanes scoring above SCORE_TH, decides on start_cr

`timescale 1ns/100ps

module oflow_conflict_resolve (
	input  logic                                        clk,
	input  logic                                        reset_N,
	input  logic                                        clear_cr,
	input  logic [oflow_pkg::PE_NUM-1:0]                score_valid,
	input  logic [oflow_pkg::PE_NUM*oflow_pkg::SCORE_W-1:0] score,
	input  logic                                        start_cr,
	output logic                                        done_cr,
	output logic                                        drop
);

	import oflow_pkg::*;

	logic [CONFLICT_W-1:0] cnt;    // conflicts so far this frame
	logic [CONFLICT_W-1:0] hits;   // conflicting lanes this cycle
	logic [CONFLICT_W:0]   sum;    // carry bit flags saturation

	always_comb begin
		hits = '0;
		for (int i = 0; i < PE_NUM; i++)
			if (score_valid[i] && score[i*SCORE_W +: SCORE_W] > SCORE_W'(SCORE_TH))
				hits = hits + 1'b1;
		sum = cnt + hits;
	end

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N)
			cnt <= '0;
		else if (clear_cr)
			cnt <= '0;                     // new frame
		else if (sum[CONFLICT_W])
			cnt <= '1;                     // saturate
		else
			cnt <= sum[CONFLICT_W-1:0];
	end

	// decision ready the cycle after start_cr
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			done_cr <= 1'b0;
			drop    <= 1'b0;
		end else begin
			done_cr <= start_cr;
			if (start_cr)
				drop <= (cnt > CONFLICT_W'(CONFLICT_TH));
		end
	end

endmodule

/* rtl/oflow_mem_buffer.sv */
// two-bank history store, reads from history bank, stages into the other
// BUF_COMMIT swaps banks; slots not staged this frame carry over

`timescale 1ns/100ps

module oflow_mem_buffer (
	input  logic                                        clk,
	input  logic                                        reset_N,
	input  oflow_ctrl_pkg::buf_cmd_t                    buf_cmd,
	input  logic [oflow_pkg::SET_W-1:0]                 set_idx,
	input  logic [oflow_pkg::PE_NUM*oflow_pkg::BBOX_W-1:0]  set_data,
	input  logic [oflow_pkg::SET_W-1:0]                 read_idx,
	output logic [oflow_pkg::PE_NUM*oflow_pkg::BBOX_W-1:0]  hist_data,
	output logic                                        done_write
);

	import oflow_pkg::*;
	import oflow_ctrl_pkg::*;

	logic [BBOX_W-1:0]   mem [2][MAX_BBOX];
	logic                bank_sel;   // history bank index
	logic [MAX_BBOX-1:0] staged;     // slots written since frame start

	// history read, same cycle as capture
	always_comb begin
		for (int i = 0; i < PE_NUM; i++)
			hist_data[i*BBOX_W +: BBOX_W] = mem[bank_sel][read_idx*PE_NUM + i];
	end

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			bank_sel   <= 1'b0;
			staged     <= '0;
			done_write <= 1'b0;
			for (int b = 0; b < 2; b++)
				for (int k = 0; k < MAX_BBOX; k++)
					mem[b][k] <= '0;   // zero history for the first frame
		end else begin
			done_write <= (buf_cmd == BUF_COMMIT);
			case (buf_cmd)
				BUF_STAGE: begin
					// set 0 opens a frame, drops any stale marks from a dropped one
					if (set_idx == '0)
						staged <= '0;
					for (int i = 0; i < PE_NUM; i++) begin
						mem[!bank_sel][set_idx*PE_NUM + i] <= set_data[i*BBOX_W +: BBOX_W];
						staged[set_idx*PE_NUM + i]         <= 1'b1;
					end
				end
				BUF_COMMIT: begin
					for (int k = 0; k < MAX_BBOX; k++)
						if (!staged[k])
							mem[!bank_sel][k] <= mem[bank_sel][k];   // carry old box
					bank_sel <= !bank_sel;
				end
				default: ;
			endcase
		end
	end

endmodule

/* rtl/oflow_tracker_top.sv */
// tracker top level, DMA set handshake in, lane scores and frame status out
// wires the core FSM, PE array, conflict resolver and history buffer

`timescale 1ns/100ps

module oflow_tracker_top (
	input  logic                                        clk,
	input  logic                                        reset_N,
	input  logic                                        frame_start,
	input  logic [oflow_pkg::BBOX_CNT_W-1:0]            num_bbox,
	input  logic                                        set_req,
	input  logic [oflow_pkg::PE_NUM*oflow_pkg::BBOX_W-1:0]  set_data,
	output logic                                        set_ack,
	output logic                                        ready_new_frame,
	output logic [oflow_pkg::PE_NUM-1:0]                score_valid,
	output logic [oflow_pkg::PE_NUM*oflow_pkg::SCORE_W-1:0] score,
	output logic [oflow_pkg::SET_W-1:0]                 score_set,
	output logic                                        frame_done,
	output logic                                        valid_id,
	output logic                                        frame_dropped,
	output logic [oflow_pkg::FRAME_NUM_W-1:0]           frame_num
);

	import oflow_pkg::*;

	// ------------------------------------------------------------------------
	// controller side
	// ------------------------------------------------------------------------
	logic                     capture;
	logic [PE_NUM-1:0]        lane_en;
	logic [SET_W-1:0]         set_idx;
	oflow_ctrl_pkg::buf_cmd_t buf_cmd;
	logic                     start_cr, clear_cr;
	logic                     done_cr, drop;
	logic                     done_write;
	logic [PE_NUM*BBOX_W-1:0] hist_data;   // history boxes for set_idx

	oflow_core_fsm_top core_fsm (
		.clk, .reset_N, .frame_start, .num_bbox, .set_req,
		.done_write, .done_cr, .drop,
		.set_ack, .ready_new_frame, .capture, .lane_en, .set_idx, .buf_cmd,
		.start_cr, .clear_cr, .frame_done, .valid_id, .frame_dropped, .frame_num
	);

	oflow_pe_array pe_array (
		.clk, .reset_N, .capture, .lane_en, .set_idx, .set_data, .hist_data,
		.score_valid, .score, .score_set
	);

	// watches the same score stream as the output
	oflow_conflict_resolve conflict_resolve (
		.clk, .reset_N, .clear_cr, .score_valid, .score, .start_cr,
		.done_cr, .drop
	);

	oflow_mem_buffer mem_buffer (
		.clk, .reset_N, .buf_cmd, .set_idx, .set_data,
		.read_idx (set_idx),   // PE reads the slots being captured
		.hist_data, .done_write
	);

endmodule

/* verification/oflow_tracker_tb.sv */
// testbench for the tracker top level
// drives frames over the DMA set handshake and checks lane scores and
// frame status against a reference model of the committed history

`timescale 1ns/100ps

module oflow_tracker_tb;

	import oflow_pkg::*;

	localparam int MAX_CYCLES = 2000;   // six frames of ~60 cycles, wide margin

	logic                      clk;
	logic                      reset_N;
	logic                      frame_start;
	logic [BBOX_CNT_W-1:0]     num_bbox;
	logic                      set_req;
	logic [PE_NUM*BBOX_W-1:0]  set_data;
	logic                      set_ack;
	logic                      ready_new_frame;
	logic [PE_NUM-1:0]         score_valid;
	logic [PE_NUM*SCORE_W-1:0] score;
	logic [SET_W-1:0]          score_set;
	logic                      frame_done, valid_id, frame_dropped;
	logic [FRAME_NUM_W-1:0]    frame_num;

	// reference model
	logic [BBOX_W-1:0]         hist [MAX_BBOX];   // last committed frame
	int                        model_fn = 0;      // committed frames
	int                        exp_set_q[$];      // per captured set
	logic [PE_NUM-1:0]         exp_mask_q[$];
	logic [PE_NUM*SCORE_W-1:0] exp_score_q[$];
	logic [PE_NUM-1:0]         exp_mask;
	logic [PE_NUM*SCORE_W-1:0] exp_scores;
	int                        exp_set;

	int   err_cnt = 0, tests_ok = 0, tests_bad = 0;
	int   cycles = 0, ack_cnt = 0;
	logic ack_prev = 1'b0;

	oflow_tracker_top dut (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout, run stopped after %0d cycles", cycles);
			$display("Test failures found");
			$finish;
		end
	end

	task automatic report_value(input string name, input int exp_v, input int got_v);
		err_cnt++;
		$display("FAIL t=%0t %s expected %0d got %0d", $time, name, exp_v, got_v);
	endtask

	task automatic report_error(input string what);
		err_cnt++;
		$display("error at %0t: %s", $time, what);
	endtask

	task automatic close_test(input string name, input int errs_before);
		if (err_cnt == errs_before) begin
			tests_ok++;
			$display("test %-26s ok", name);
		end else begin
			tests_bad++;
			$display("test %-26s %0d errors", name, err_cnt - errs_before);
		end
	endtask

	// |dx| + |dy| of two boxes
	function automatic int box_score(input logic [BBOX_W-1:0] a, input logic [BBOX_W-1:0] b);
		int dx, dy;
		dx = int'(a[15:8]) - int'(b[15:8]);
		dy = int'(a[7:0]) - int'(b[7:0]);
		return (dx < 0 ? -dx : dx) + (dy < 0 ? -dy : dy);
	endfunction

	function automatic logic [7:0] clamp_coord(input logic [7:0] v, input int d);
		int r;
		r = int'(v) + d;
		return (r < 0) ? 8'd0 : (r > 255) ? 8'd255 : 8'(r);
	endfunction

	// ------------------------------------------------------------------------
	// protocol and frame-end assertions
	// ------------------------------------------------------------------------
	ack_rise_on_req: assert property (@(posedge clk) disable iff (!reset_N)
		$rose(set_ack) |-> $past(set_req))
		else report_error("set_ack rose while set_req was low");

	ack_fall_after_req: assert property (@(posedge clk) disable iff (!reset_N)
		$fell(set_ack) |-> !$past(set_req))
		else report_error("set_ack fell while set_req was still high");

	done_one_cycle: assert property (@(posedge clk) disable iff (!reset_N)
		frame_done |=> !frame_done)
		else report_error("frame_done held longer than one cycle");

	drop_reported: assert property (@(posedge clk) disable iff (!reset_N)
		frame_dropped |-> frame_done && !valid_id)
		else report_error("frame_dropped outside frame_done or with valid_id");

	// score stream vs model, sampled mid-cycle
	always @(negedge clk) begin
		if (reset_N && score_valid != '0) begin
			if (exp_mask_q.size() == 0) begin
				report_error("score_valid set with no captured set pending");
			end else begin
				exp_mask   = exp_mask_q.pop_front();
				exp_scores = exp_score_q.pop_front();
				exp_set    = exp_set_q.pop_front();
				assert (score_valid == exp_mask)
					else report_value("score_valid", exp_mask, score_valid);
				assert (score_set == SET_W'(exp_set))
					else report_value("score_set", exp_set, score_set);
				for (int i = 0; i < PE_NUM; i++)
					if (exp_mask[i])
						assert (score[i*SCORE_W +: SCORE_W] == exp_scores[i*SCORE_W +: SCORE_W])
							else report_value($sformatf("score lane %0d", i),
								exp_scores[i*SCORE_W +: SCORE_W], score[i*SCORE_W +: SCORE_W]);
			end
		end
		if (set_ack && !ack_prev)
			ack_cnt++;   // one per delivered set
		ack_prev = set_ack;
	end

	// ------------------------------------------------------------------------
	// one frame: mode 0 fresh boxes, 1 small motion, 2 five boxes jump far
	// ------------------------------------------------------------------------
	task automatic run_frame(input int nb, input int mode, input bit extra_start);
		logic [BBOX_W-1:0]         boxes [MAX_BBOX];
		logic [PE_NUM*SCORE_W-1:0] sc;
		logic [PE_NUM-1:0]         mask;
		int                        nsets, conflicts;
		bit                        exp_drop;
		nsets     = (nb + PE_NUM - 1) / PE_NUM;
		conflicts = 0;
		for (int k = 0; k < MAX_BBOX; k++) begin
			if (mode == 0) begin
				boxes[k] = {8'(20 + $urandom_range(215)), 8'(20 + $urandom_range(215))};
			end else begin
				boxes[k][15:8] = clamp_coord(hist[k][15:8], int'($urandom_range(10)) - 5);
				boxes[k][7:0]  = clamp_coord(hist[k][7:0], int'($urandom_range(10)) - 5);
			end
			if (mode == 2 && k < 5)   // away from the edge, no clamping
				boxes[k][15:8] = (hist[k][15:8] < 8'd128) ? hist[k][15:8] + 8'd60
				                                          : hist[k][15:8] - 8'd60;
			if (k < nb && box_score(boxes[k], hist[k]) > SCORE_TH)
				conflicts++;
		end
		exp_drop = (model_fn != 0) && (conflicts > CONFLICT_TH);

		@(negedge clk);
		while (!ready_new_frame)
			@(negedge clk);
		@(posedge clk);
		frame_start <= 1'b1;
		num_bbox    <= BBOX_CNT_W'(nb);
		ack_cnt = 0;
		@(posedge clk);
		frame_start <= 1'b0;

		for (int s = 0; s < nsets; s++) begin
			repeat ($urandom_range(3))
				@(posedge clk);
			@(negedge clk);
			while (set_ack)   // previous set fully released
				@(negedge clk);
			for (int i = 0; i < PE_NUM; i++) begin
				mask[i] = (s * PE_NUM + i < nb);
				sc[i*SCORE_W +: SCORE_W] =
					SCORE_W'(box_score(boxes[s*PE_NUM+i], hist[s*PE_NUM+i]));
			end
			exp_set_q.push_back(s);
			exp_mask_q.push_back(mask);
			exp_score_q.push_back(sc);
			@(posedge clk);
			set_req <= 1'b1;
			for (int i = 0; i < PE_NUM; i++)
				set_data[i*BBOX_W +: BBOX_W] <= boxes[s*PE_NUM+i];
			@(negedge clk);
			while (!set_ack)
				@(negedge clk);
			if (extra_start && s == 0)
				assert (!ready_new_frame)
					else report_error("controller ready in the middle of a frame");
			@(posedge clk);
			set_req <= 1'b0;
			if (extra_start && s == 0) begin
				frame_start <= 1'b1;   // must be ignored, controller busy
				num_bbox    <= BBOX_CNT_W'(1);
				@(posedge clk);
				frame_start <= 1'b0;
				num_bbox    <= BBOX_CNT_W'(nb);
			end
		end

		@(negedge clk);
		while (!frame_done)
			@(negedge clk);
		assert (frame_dropped == exp_drop)
			else report_value("frame_dropped", exp_drop, frame_dropped);
		assert (valid_id == (!exp_drop && model_fn != 0))
			else report_value("valid_id", !exp_drop && model_fn != 0, valid_id);
		if (!exp_drop) begin
			model_fn = (model_fn + 1) % 256;
			for (int k = 0; k < nsets * PE_NUM; k++)
				hist[k] = boxes[k];   // whole sets land in history
		end
		assert (frame_num == FRAME_NUM_W'(model_fn))
			else report_value("frame_num", model_fn, frame_num);
		repeat (6) begin
			@(negedge clk);
			assert (!frame_done && ready_new_frame)
				else report_error("extra frame_done or controller busy after frame end");
		end
		assert (ack_cnt == nsets)
			else report_value("set_ack count", nsets, ack_cnt);
		assert (exp_mask_q.size() == 0)
			else report_error("captured sets never produced scores");
	endtask

	// ------------------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------------------
	initial begin
		int e0;
		void'($urandom(2498));
		reset_N     = 1'b0;
		frame_start = 1'b0;
		num_bbox    = '0;
		set_req     = 1'b0;
		set_data    = '0;
		for (int k = 0; k < MAX_BBOX; k++)
			hist[k] = '0;   // zero history before the first frame
		repeat (16)
			@(posedge clk);
		reset_N <= 1'b1;

		e0 = err_cnt;
		@(negedge clk);
		assert (ready_new_frame == 1'b1) else report_value("ready_new_frame", 1, ready_new_frame);
		assert (set_ack == 1'b0) else report_value("set_ack", 0, set_ack);
		assert (score_valid == '0) else report_value("score_valid", 0, score_valid);
		assert (frame_done == 1'b0) else report_value("frame_done", 0, frame_done);
		assert (valid_id == 1'b0) else report_value("valid_id", 0, valid_id);
		assert (frame_dropped == 1'b0) else report_value("frame_dropped", 0, frame_dropped);
		assert (frame_num == '0) else report_value("frame_num", 0, frame_num);
		close_test("reset state", e0);

		e0 = err_cnt;
		run_frame(6, 0, 1'b0);
		close_test("first frame, 6 boxes", e0);

		e0 = err_cnt;
		run_frame(16, 1, 1'b0);
		run_frame(9, 1, 1'b0);
		close_test("small motion kept", e0);

		e0 = err_cnt;
		run_frame(16, 2, 1'b0);
		close_test("conflict drop", e0);

		e0 = err_cnt;
		run_frame(12, 1, 1'b0);
		close_test("kept frame after drop", e0);

		e0 = err_cnt;
		run_frame(8, 1, 1'b1);
		close_test("frame_start while busy", e0);

		$display("tests passed: %0d, failed: %0d, errors: %0d", tests_ok, tests_bad, err_cnt);
		if (err_cnt == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

/* filelist.f */
common/oflow_pkg.sv
common/oflow_ctrl_pkg.sv
oflow_core/oflow_core_fsm_top.sv
oflow_core/oflow_pe_array.sv
oflow_core/oflow_conflict_resolve.sv
rtl/oflow_mem_buffer.sv
rtl/oflow_tracker_top.sv
verification/oflow_tracker_tb.sv

/* Bender.yml */
package:
  name: oflow_tracker

sources:
  - files:
      - common/oflow_pkg.sv
      - common/oflow_ctrl_pkg.sv
      - oflow_core/oflow_core_fsm_top.sv
      - oflow_core/oflow_pe_array.sv
      - oflow_core/oflow_conflict_resolve.sv
      - rtl/oflow_mem_buffer.sv
      - rtl/oflow_tracker_top.sv
  - target: test
    files:
      - verification/oflow_tracker_tb.sv
